/* include/conv_cfg.svh */
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// feature map shape, one input bank per map row
`define CONV_MAP_ROWS 8
`define CONV_MAP_COLS 16

// square kernel, stride 1
`define CONV_K 3

// pixels packed into one bank word
`define CONV_PIX_PER_WORD 4

// one PE per output filter
`define CONV_NUM_PE 4

// pixel and weight width
`define CONV_PIX_W 8

// dot product result width
`define CONV_ACC_W 24

`endif

/* rtl/conv_pkg.sv */
`include "conv_cfg.svh"

package conv_pkg;

	// valid output positions for a stride-1 kernel
	localparam int OUT_ROWS = `CONV_MAP_ROWS - `CONV_K + 1;
	localparam int OUT_COLS = `CONV_MAP_COLS - `CONV_K + 1;
	localparam int NUM_OUT = OUT_ROWS * OUT_COLS;
	localparam int WIN_PIX = `CONV_K * `CONV_K;

	typedef logic signed [`CONV_PIX_W-1:0] pixel_t;
	typedef logic signed [`CONV_ACC_W-1:0] acc_t;

	typedef logic [$clog2(`CONV_MAP_ROWS)-1:0] row_idx_t;
	typedef logic [$clog2(`CONV_MAP_COLS)-1:0] col_idx_t;
	typedef logic [$clog2(`CONV_MAP_COLS / `CONV_PIX_PER_WORD)-1:0] word_addr_t;

	// pixel 0 sits in the top byte of a word
	typedef logic [`CONV_PIX_PER_WORD*`CONV_PIX_W-1:0] bank_word_t;

	// element r*K+c in the top bytes first, same order for the weights
	typedef logic [WIN_PIX*`CONV_PIX_W-1:0] window_t;
	typedef logic [WIN_PIX*`CONV_PIX_W-1:0] kernel_t;

	typedef logic [$clog2(NUM_OUT)-1:0] out_addr_t;

	typedef enum logic [1:0] {
		st_idle,
		st_scan,
		st_done
	} scan_state_t;

	// one output position moving down the pipeline
	typedef struct packed {
		logic     valid;
		row_idx_t row;
		col_idx_t col;
		logic     last;
	} scan_pos_t;

endpackage

/* rtl/conv_scan.sv */
`timescale 1ns/1ps

module conv_scan
	import conv_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      run,
	input  logic      last_written,
	output scan_pos_t pos,
	output logic      tile_done
);

	scan_state_t state;
	scan_state_t state_next;
	row_idx_t    row_cnt;
	col_idx_t    col_cnt;
	logic        issue_done;
	logic        at_end;
	logic        at_row_end;

	assign at_row_end = (col_cnt == col_idx_t'(OUT_COLS - 1));
	assign at_end = at_row_end && (row_cnt == row_idx_t'(OUT_ROWS - 1));

	// done is held until the host drops run
	assign tile_done = (state == st_done);

	always_comb
	begin
		state_next = state;
		case (state)
			st_idle:
			begin
				if (run)
					state_next = st_scan;
			end
			st_scan:
			begin
				// wait for the final write, not the final issue
				if (last_written)
					state_next = st_done;
			end
			st_done:
			begin
				if (!run)
					state_next = st_idle;
			end
			default:
				state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			state <= st_idle;
		else
			state <= state_next;
	end

	// one position per cycle, row major
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			row_cnt <= '0;
			col_cnt <= '0;
			issue_done <= 1'b0;
			pos <= '0;
		end
		else
		begin
			pos <= '0;
			if (state == st_scan && !issue_done)
			begin
				pos.valid <= 1'b1;
				pos.row <= row_cnt;
				pos.col <= col_cnt;
				pos.last <= at_end;
				if (at_end)
				begin
					row_cnt <= '0;
					col_cnt <= '0;
					issue_done <= 1'b1;
				end
				else if (at_row_end)
				begin
					row_cnt <= row_cnt + 1'b1;
					col_cnt <= '0;
				end
				else
					col_cnt <= col_cnt + 1'b1;
			end
			else if (state == st_idle)
				issue_done <= 1'b0;
		end
	end

endmodule

/* rtl/conv_tile.sv */
`timescale 1ns/1ps
`include "conv_cfg.svh"

module conv_tile
	import conv_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       run,
	input  kernel_t    weights   [0:`CONV_NUM_PE-1],
	output word_addr_t bank_addr [0:`CONV_MAP_ROWS-1],
	output logic       bank_oen  [0:`CONV_MAP_ROWS-1],
	input  bank_word_t bank_data [0:`CONV_MAP_ROWS-1],
	output logic       out_wen,
	output out_addr_t  out_addr,
	output acc_t       out_data  [0:`CONV_NUM_PE-1],
	output logic       tile_done
);

	scan_pos_t pos;
	scan_pos_t win_pos;
	window_t   window;
	logic      last_written;

	conv_scan scan_i (
		.clk          (clk),
		.rst          (rst),
		.run          (run),
		.last_written (last_written),
		.pos          (pos),
		.tile_done    (tile_done)
	);

	window_fetch fetch_i (
		.clk       (clk),
		.rst       (rst),
		.pos       (pos),
		.bank_data (bank_data),
		.bank_addr (bank_addr),
		.bank_oen  (bank_oen),
		.window    (window),
		.win_pos   (win_pos)
	);

	// every PE sees the same window with its own filter
	genvar g;
	generate
		for (g = 0; g < `CONV_NUM_PE; g++)
		begin : g_pe
			mac_pe pe_i (
				.clk     (clk),
				.rst     (rst),
				.window  (window),
				.weights (weights[g]),
				.result  (out_data[g])
			);
		end
	endgenerate

	// write control lines up with the PE result register
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			out_wen <= 1'b1;
			last_written <= 1'b0;
		end
		else
		begin
			out_wen <= !win_pos.valid;
			last_written <= win_pos.valid && win_pos.last;
		end
	end

	// linear output address, row * OUT_COLS + col
	always_ff @(posedge clk)
	begin
		out_addr <= out_addr_t'(int'(win_pos.row) * OUT_COLS + int'(win_pos.col));
	end

endmodule

/* rtl/mac_pe.sv */
`timescale 1ns/1ps

module mac_pe
	import conv_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  window_t window,
	input  kernel_t weights,
	output acc_t    result
);

	acc_t sum;

	// nine signed products, summed at full result width
	always_comb
	begin
		pixel_t px;
		pixel_t wt;
		acc_t   prod;
		sum = '0;
		for (int i = 0; i < WIN_PIX; i++)
		begin
			px = window[$bits(window_t)-1-i*$bits(pixel_t) -: $bits(pixel_t)];
			wt = weights[$bits(kernel_t)-1-i*$bits(pixel_t) -: $bits(pixel_t)];
			prod = px * wt;
			sum = sum + prod;
		end
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			result <= '0;
		else
			result <= sum;
	end

endmodule

/* rtl/window_fetch.sv */
`timescale 1ns/1ps
`include "conv_cfg.svh"

module window_fetch
	import conv_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  scan_pos_t  pos,
	input  bank_word_t bank_data [0:`CONV_MAP_ROWS-1],
	output word_addr_t bank_addr [0:`CONV_MAP_ROWS-1],
	output logic       bank_oen  [0:`CONV_MAP_ROWS-1],
	output window_t    window,
	output scan_pos_t  win_pos
);

	scan_pos_t  pos_d1;
	scan_pos_t  pos_d2;
	word_addr_t word_sel;
	window_t    win_next;

	// pixel p of a bank word, pixel 0 at the top
	function automatic pixel_t word_pix(input bank_word_t word, input int p);
		return word[$bits(bank_word_t)-1-p*`CONV_PIX_W -: `CONV_PIX_W];
	endfunction

	function automatic pixel_t win_pix(input window_t win, input int idx);
		return win[$bits(window_t)-1-idx*`CONV_PIX_W -: `CONV_PIX_W];
	endfunction

	// phases 2 and 3 only need the first pixels of the next word
	always_comb
	begin
		if (pos.col[1])
			word_sel = pos.col[3:2] + 1'b1;
		else
			word_sel = pos.col[3:2];
	end

	// address stage, banks row to row+K-1 read
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			for (int b = 0; b < `CONV_MAP_ROWS; b++)
			begin
				bank_addr[b] <= '0;
				bank_oen[b] <= 1'b1;
			end
		end
		else
		begin
			for (int b = 0; b < `CONV_MAP_ROWS; b++)
			begin
				if (pos.valid && b >= int'(pos.row) && b < int'(pos.row) + `CONV_K)
				begin
					bank_addr[b] <= word_sel;
					bank_oen[b] <= 1'b0;
				end
				else
				begin
					bank_addr[b] <= '0;
					bank_oen[b] <= 1'b1;
				end
			end
		end
	end

	// position copies for the address and data cycles
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			pos_d1 <= '0;
			pos_d2 <= '0;
			win_pos <= '0;
		end
		else
		begin
			pos_d1 <= pos;
			pos_d2 <= pos_d1;
			win_pos <= pos_d2;
		end
	end

	always_comb
	begin
		bank_word_t row_word;
		int phase;
		win_next = window;
		phase = int'(pos_d2.col[1:0]);
		for (int r = 0; r < `CONV_K; r++)
		begin
			row_word = bank_data[int'(pos_d2.row) + r];
			if (phase < 2)
			begin
				// fresh load, window fits in the current word
				for (int c = 0; c < `CONV_K; c++)
					win_next[$bits(window_t)-1-(r*`CONV_K+c)*`CONV_PIX_W -: `CONV_PIX_W] =
						word_pix(row_word, phase + c);
			end
			else
			begin
				// slide by one column, new pixel from the next word
				for (int c = 0; c < `CONV_K - 1; c++)
					win_next[$bits(window_t)-1-(r*`CONV_K+c)*`CONV_PIX_W -: `CONV_PIX_W] =
						win_pix(window, r*`CONV_K + c + 1);
				win_next[$bits(window_t)-1-(r*`CONV_K+`CONV_K-1)*`CONV_PIX_W -: `CONV_PIX_W] =
					word_pix(row_word, phase - 2);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (pos_d2.valid)
			window <= win_next;
	end

endmodule

/* run.sh */
#!/bin/sh
# build and run the conv_tile testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_tile \
	-f sources.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_conv_tile
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0

/* sources.f */
+incdir+include
rtl/conv_pkg.sv
rtl/conv_scan.sv
rtl/window_fetch.sv
rtl/mac_pe.sv
rtl/conv_tile.sv
tb/conv_tile_asserts.sv
tb/tb_conv_tile.sv

/* tb/conv_tile_asserts.sv */
`timescale 1ns/1ps
`include "conv_cfg.svh"

module conv_tile_asserts
	import conv_pkg::*;
(
	input logic       clk,
	input logic       rst,
	input logic       run,
	input scan_pos_t  pos,
	input word_addr_t bank_addr [0:`CONV_MAP_ROWS-1],
	input logic       bank_oen  [0:`CONV_MAP_ROWS-1],
	input logic       out_wen,
	input out_addr_t  out_addr,
	input logic       tile_done
);

	logic [`CONV_MAP_ROWS-1:0] oen_vec;
	logic [`CONV_MAP_ROWS-1:0] sel_mask;
	logic [`CONV_MAP_ROWS-1:0] read_mask;
	word_addr_t                read_word;
	logic                      addr_match;
	logic                      started;

	// kernel rows row to row+K-1 of the issued position
	always_comb
	begin
		sel_mask = '0;
		if (pos.valid)
			for (int r = 0; r < `CONV_K; r++)
				sel_mask[int'(pos.row) + r] = 1'b1;
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			read_mask <= '0;
			read_word <= '0;
			started <= 1'b0;
		end
		else
		begin
			read_mask <= sel_mask;
			// phases 2 and 3 round up into the next word
			read_word <= word_addr_t'((int'(pos.col) + 2) / `CONV_PIX_PER_WORD);
			started <= started | run;
		end
	end

	always_comb
	begin
		addr_match = 1'b1;
		for (int b = 0; b < `CONV_MAP_ROWS; b++)
		begin
			oen_vec[b] = bank_oen[b];
			if (!bank_oen[b] && bank_addr[b] != read_word)
				addr_match = 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		!started |-> out_wen && (&oen_vec) && !tile_done)
	else $error("outputs active before the first run");

	assert property (@(posedge clk) disable iff (rst)
		(oen_vec == ~read_mask) && addr_match)
	else $error("bank enables or addresses do not match the fetched position");

	assert property (@(posedge clk) disable iff (rst)
		$fell(out_wen) |-> out_addr == '0)
	else $error("first write of a tile is not at address zero");

	assert property (@(posedge clk) disable iff (rst)
		!out_wen && out_addr != out_addr_t'(NUM_OUT - 1)
		|=> !out_wen && out_addr == $past(out_addr) + 1'b1)
	else $error("writes are not consecutive");

	assert property (@(posedge clk) disable iff (rst)
		$rose(tile_done) |-> $past(!out_wen && out_addr == out_addr_t'(NUM_OUT - 1)))
	else $error("tile_done rose without the last write before it");

	assert property (@(posedge clk) disable iff (rst)
		tile_done && run |=> tile_done)
	else $error("tile_done fell while run was high");

	assert property (@(posedge clk) disable iff (rst)
		tile_done && !run |=> !tile_done)
	else $error("tile_done stayed high after run fell");

endmodule

/* tb/tb_conv_tile.sv */
`timescale 1ns/1ps
`include "conv_cfg.svh"

module tb_conv_tile
	import conv_pkg::*;
;

	localparam int CLK_NS = 4;
	localparam int NUM_TILES = 2;
	localparam int TILE_CYCLES = 6 + NUM_OUT + 10;
	localparam int WORDS = `CONV_MAP_COLS / `CONV_PIX_PER_WORD;

	logic       clk = 1'b0;
	logic       rst;
	logic       run;
	kernel_t    weights   [0:`CONV_NUM_PE-1];
	word_addr_t bank_addr [0:`CONV_MAP_ROWS-1];
	logic       bank_oen  [0:`CONV_MAP_ROWS-1];
	bank_word_t bank_data [0:`CONV_MAP_ROWS-1] = '{default: '0};
	logic       out_wen;
	out_addr_t  out_addr;
	acc_t       out_data  [0:`CONV_NUM_PE-1];
	logic       tile_done;

	// reference image and kernels, plus the bank memory image
	pixel_t     img  [0:`CONV_MAP_ROWS-1][0:`CONV_MAP_COLS-1];
	pixel_t     kern [0:`CONV_NUM_PE-1][0:WIN_PIX-1];
	bank_word_t mem  [0:`CONV_MAP_ROWS-1][0:WORDS-1];
	word_addr_t rd_addr [0:`CONV_MAP_ROWS-1];
	logic       rd_en   [0:`CONV_MAP_ROWS-1];

	logic [31:0] rng;
	int          tile_num;
	int          write_count = 0;

	conv_tile dut_i (
		.clk       (clk),
		.rst       (rst),
		.run       (run),
		.weights   (weights),
		.bank_addr (bank_addr),
		.bank_oen  (bank_oen),
		.bank_data (bank_data),
		.out_wen   (out_wen),
		.out_addr  (out_addr),
		.out_data  (out_data),
		.tile_done (tile_done)
	);

	bind conv_tile conv_tile_asserts asserts_i (
		.clk       (clk),
		.rst       (rst),
		.run       (run),
		.pos       (pos),
		.bank_addr (bank_addr),
		.bank_oen  (bank_oen),
		.out_wen   (out_wen),
		.out_addr  (out_addr),
		.tile_done (tile_done)
	);

	always #(CLK_NS / 2) clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int expected_dot(input int pe, input int row, input int col);
		int sum;
		sum = 0;
		for (int r = 0; r < `CONV_K; r++)
			for (int c = 0; c < `CONV_K; c++)
				sum += int'(img[row + r][col + c]) * int'(kern[pe][r * `CONV_K + c]);
		return sum;
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected)
		else
		begin
			$display("ERR %s expected %0d actual %0d", name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond)
		else
		begin
			$display("%s", what);
			$display("RESULT: FAIL");
			$fatal(1, "%s", what);
		end
	endtask

	// new random image and kernels, packed into bank words and the weight bus
	task automatic fill_tile();
		for (int r = 0; r < `CONV_MAP_ROWS; r++)
			for (int c = 0; c < `CONV_MAP_COLS; c++)
			begin
				rng = xorshift32(rng);
				img[r][c] = pixel_t'(rng[7:0]);
			end
		for (int pe = 0; pe < `CONV_NUM_PE; pe++)
			for (int i = 0; i < WIN_PIX; i++)
			begin
				rng = xorshift32(rng);
				kern[pe][i] = pixel_t'(rng[7:0]);
				weights[pe][$bits(kernel_t)-1-i*`CONV_PIX_W -: `CONV_PIX_W] = kern[pe][i];
			end
		for (int r = 0; r < `CONV_MAP_ROWS; r++)
			for (int w = 0; w < WORDS; w++)
				for (int p = 0; p < `CONV_PIX_PER_WORD; p++)
					mem[r][w][$bits(bank_word_t)-1-p*`CONV_PIX_W -: `CONV_PIX_W] =
						img[r][w * `CONV_PIX_PER_WORD + p];
	endtask

	// bank SRAMs, read request taken at the clock edge, data driven half a cycle later
	always @(posedge clk)
	begin
		for (int b = 0; b < `CONV_MAP_ROWS; b++)
		begin
			rd_en[b] <= !bank_oen[b];
			rd_addr[b] <= bank_addr[b];
		end
	end

	always @(negedge clk)
	begin
		for (int b = 0; b < `CONV_MAP_ROWS; b++)
			if (rd_en[b])
				bank_data[b] <= mem[b][rd_addr[b]];
	end

	// every write is compared with the reference dot products
	always @(negedge clk)
	begin
		int row;
		int col;
		if (!rst && !out_wen)
		begin
			check_value($sformatf("tile%0d_addr", tile_num), write_count % NUM_OUT,
				int'(out_addr));
			row = int'(out_addr) / OUT_COLS;
			col = int'(out_addr) % OUT_COLS;
			for (int pe = 0; pe < `CONV_NUM_PE; pe++)
				check_value($sformatf("tile%0d_pe%0d_r%0d_c%0d", tile_num, pe, row, col),
					expected_dot(pe, row, col), int'(out_data[pe]));
			write_count++;
		end
	end

	task automatic run_tile(input int t);
		int start_count;
		tile_num = t;
		fill_tile();
		start_count = write_count;
		run = 1'b1;
		while (!tile_done)
			@(negedge clk);
		check_value($sformatf("tile%0d_writes", t), NUM_OUT, write_count - start_count);
		// done has to hold while run stays high
		repeat (5)
		begin
			@(negedge clk);
			check_true(tile_done, "tile_done fell while run was still high");
		end
		run = 1'b0;
		@(negedge clk);
		check_true(!tile_done, "tile_done stayed high after run went low");
		repeat (3) @(negedge clk);
	endtask

	initial
	begin
		rst = 1'b1;
		run = 1'b0;
		for (int pe = 0; pe < `CONV_NUM_PE; pe++)
			weights[pe] = '0;
		rng = 32'h0785a521;
		tile_num = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// some idle cycles before the first run
		repeat (4) @(negedge clk);
		for (int t = 0; t < NUM_TILES; t++)
			run_tile(t);
		if (write_count == NUM_TILES * NUM_OUT)
		begin
			$display("RESULT: PASS");
			$finish;
		end
		else
		begin
			$display("wrong total write count %0d", write_count);
			$display("RESULT: FAIL");
			$fatal(1, "wrong total write count");
		end
	end

	initial
	begin
		#((3 + 10 + 2 * TILE_CYCLES * NUM_TILES) * CLK_NS);
		$display("watchdog timeout, the tiles did not complete in time");
		$display("RESULT: FAIL");
		$fatal(1, "watchdog timeout");
	end

endmodule
